// File: include/core_logic_defines.svh
/*
  Shared constants for the board controller core logic.
  Include this header wherever byte widths, device selects or opcodes are needed.
*/
`ifndef CORE_LOGIC_DEFINES_SVH
`define CORE_LOGIC_DEFINES_SVH

// Bits in one SPI byte
`define BYTE_WIDTH 8

// Width of the bit counter that walks through one byte
`define BIT_INDEX_WIDTH 3

// Width of the encoded coprocessor device select
`define DEV_SELECT_WIDTH 2

// Coprocessor device-select codes
`define DEV_SELECT_RAM     0
`define DEV_SELECT_COMMAND 1
`define DEV_SELECT_NONE    3

// MCU session opcodes, sent as the first byte after mcu_nss falls
// Opcode 0 puts the MCU side back to idle
`define MCU_STATE_OPCODE        0
`define MCU_STATE_ACCESS_RAM    1
`define MCU_STATE_WRITE_COMMAND 2

// Number of bytes the command buffer can hold
`define COMMAND_BYTES 4

`endif

// File: hw/spi_pkg.sv
/*
  Types for one SPI link: the pin bundle and the received byte with its strobe.
  Import it inside any module that handles SPI pins or received bytes.
*/
`include "core_logic_defines.svh"

package spi_pkg;

  // The three master-driven pins of one link
  typedef struct packed {
    logic nss;
    logic sck;
    logic mosi;
  } spi_pins_t;

  // Pin levels of an idle link, deselected with the clock low
  localparam spi_pins_t SPI_PINS_IDLE = '{nss: 1'b1, sck: 1'b0, mosi: 1'b0};

  // A received byte; valid is high for exactly one clk cycle per byte
  typedef struct packed {
    logic                   valid;
    logic [`BYTE_WIDTH-1:0] data;
  } spi_byte_t;

endpackage

// File: hw/core_logic_pkg.sv
/*
  Types for the MCU session decoder and the command buffer.
  Import it inside modules that look at the MCU state or the buffer contents.
*/
`include "core_logic_defines.svh"

package core_logic_pkg;

  // Where the MCU side currently is within a session
  typedef enum logic [1:0] {
    IDLE,
    ACCESS_RAM,
    WRITE_COMMAND,
    IGNORE
  } mcu_state_t;

  // Opcode view of a byte
  // The class nibble must be zero for the byte to be a known opcode
  typedef struct packed {
    logic [3:0] op_class;
    logic [3:0] op;
  } mcu_opcode_t;

  // One received MCU byte, read either as data or as an opcode
  typedef union packed {
    logic [`BYTE_WIDTH-1:0] raw;
    mcu_opcode_t            opcode;
  } mcu_byte_u;

  // Index into the command buffer
  typedef logic [1:0] cmd_index_t;

  // Storage of the whole command buffer
  typedef logic [`COMMAND_BYTES-1:0][`BYTE_WIDTH-1:0] cmd_mem_t;

endpackage

// File: hw/spi_byte_slave.sv
/*
  SPI slave for one link, mode 0 and LSB first, sampled on the system clock.
  Delivers each received byte with a one-cycle strobe and requests the next
  transmit byte through tx_next, which the source must answer in the same cycle.
*/
`timescale 1ns/1ps
`include "core_logic_defines.svh"

module spi_byte_slave (
  input  logic                   clk,
  input  logic                   reset,
  input  spi_pkg::spi_pins_t     pins,
  input  logic [`BYTE_WIDTH-1:0] tx_byte,
  output spi_pkg::spi_byte_t     rx,
  output logic                   start,
  output logic                   tx_next,
  output logic                   miso
);
  import spi_pkg::*;

  spi_pins_t                  pins_meta;
  spi_pins_t                  pins_sync;
  logic                       sck_prev;
  logic                       nss_prev;
  logic                       sck_rise;
  logic                       sck_fall;
  logic                       nss_fall;
  logic [`BIT_INDEX_WIDTH-1:0] bit_count;
  logic                       byte_done;
  logic                       active;
  logic [`BYTE_WIDTH-1:0]     rx_shift;
  logic [`BYTE_WIDTH-1:0]     tx_shift;

  // Edges are taken on the synchronized copy only
  assign sck_rise = pins_sync.sck & ~sck_prev;
  assign sck_fall = ~pins_sync.sck & sck_prev;
  assign nss_fall = ~pins_sync.nss & nss_prev;

  always_ff @(posedge clk) begin
    if (reset) begin
      pins_meta <= SPI_PINS_IDLE;
      pins_sync <= SPI_PINS_IDLE;
      sck_prev  <= 1'b0;
      nss_prev  <= 1'b1;
      bit_count <= '0;
      byte_done <= 1'b0;
      start     <= 1'b0;
      active    <= 1'b0;
    end else begin
      // Two-flop synchronizer on all three pins
      pins_meta <= pins;
      pins_sync <= pins_meta;
      sck_prev  <= pins_sync.sck;
      nss_prev  <= pins_sync.nss;
      start     <= nss_fall;
      byte_done <= 1'b0;
      // The first transmit byte is loaded together with start
      if (start) begin
        active <= 1'b1;
      end else if (pins_sync.nss) begin
        active <= 1'b0;
      end
      if (pins_sync.nss) begin
        bit_count <= '0;
      end else if (sck_rise) begin
        bit_count <= bit_count + 1'b1;
        byte_done <= (bit_count == `BIT_INDEX_WIDTH'(`BYTE_WIDTH - 1));
      end
    end
  end

  // Shift registers carry payload only
  always_ff @(posedge clk) begin
    // Data arrives LSB first, so new bits enter at the top
    if (sck_rise && !pins_sync.nss) begin
      rx_shift <= {pins_sync.mosi, rx_shift[`BYTE_WIDTH-1:1]};
    end
    if (tx_next) begin
      tx_shift <= tx_byte;
    end else if (sck_fall && active && bit_count != '0) begin
      // Falling edge after a sampled bit moves the next bit onto miso
      // A count of zero means the byte just ended and a fresh byte sits in tx_shift
      tx_shift <= tx_shift >> 1;
    end
  end

  assign rx      = '{valid: byte_done, data: rx_shift};
  assign tx_next = start | byte_done;

  // miso stays low while this link is not in a session
  assign miso = active & tx_shift[0];

endmodule

// File: hw/mcu_state_machine.sv
/*
  Session decoder for the MCU link.
  The first byte of each session picks the mode, later bytes are steered
  to the command buffer while in WRITE_COMMAND.
*/
`timescale 1ns/1ps
`include "core_logic_defines.svh"

module mcu_state_machine (
  input  logic                      clk,
  input  logic                      reset,
  input  spi_pkg::spi_byte_t        rx,
  input  logic                      start,
  input  logic                      nss_high,
  output core_logic_pkg::mcu_state_t mcu_state,
  output logic                      cmd_write,
  output logic [`BYTE_WIDTH-1:0]    cmd_data,
  output logic                      cmd_rewind
);
  import core_logic_pkg::*;

  logic       nss_meta;
  logic       nss_sync;
  logic       first_byte;
  mcu_byte_u  rx_byte;
  mcu_state_t opcode_state;

  assign rx_byte.raw = rx.data;

  // Only class zero holds valid opcodes; anything else is ignored for the session
  always_comb begin
    opcode_state = IGNORE;
    if (rx_byte.opcode.op_class == 4'h0) begin
      case (rx_byte.opcode.op)
        `MCU_STATE_OPCODE:        opcode_state = IDLE;
        `MCU_STATE_ACCESS_RAM:    opcode_state = ACCESS_RAM;
        `MCU_STATE_WRITE_COMMAND: opcode_state = WRITE_COMMAND;
        default:                  opcode_state = IGNORE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      nss_meta   <= 1'b1;
      nss_sync   <= 1'b1;
      first_byte <= 1'b0;
      mcu_state  <= IDLE;
      cmd_write  <= 1'b0;
      cmd_rewind <= 1'b0;
    end else begin
      // nss_high is the raw pin, synchronized here
      // Together with the state register this gives the 3 cycle return to IDLE
      nss_meta   <= nss_high;
      nss_sync   <= nss_meta;
      cmd_write  <= 1'b0;
      cmd_rewind <= 1'b0;
      if (nss_sync) begin
        mcu_state <= IDLE;
      end
      // start takes priority so a session never loses its opcode byte
      if (start) begin
        first_byte <= 1'b1;
      end else if (nss_sync) begin
        first_byte <= 1'b0;
      end
      if (rx.valid && !nss_sync) begin
        if (first_byte) begin
          first_byte <= 1'b0;
          mcu_state  <= opcode_state;
          // A new write-command session replaces the old command
          cmd_rewind <= (opcode_state == WRITE_COMMAND);
        end else if (mcu_state == WRITE_COMMAND) begin
          cmd_write <= 1'b1;
        end
      end
    end
  end

  // Data byte travels alongside the write strobe
  always_ff @(posedge clk) begin
    if (rx.valid) begin
      cmd_data <= rx_byte.raw;
    end
  end

endmodule

// File: hw/command_buffer.sv
/*
  Small command store written by the MCU and read back by the coprocessor.
  Reads return 0 once they run past the bytes written in the last session.
*/
`timescale 1ns/1ps
`include "core_logic_defines.svh"

module command_buffer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cmd_write,
  input  logic                   cmd_rewind,
  input  logic [`BYTE_WIDTH-1:0] cmd_data,
  input  logic                   read_rewind,
  input  logic                   tx_next,
  output logic [`BYTE_WIDTH-1:0] tx_byte
);
  import core_logic_pkg::*;

  localparam cmd_index_t LAST_INDEX = cmd_index_t'(`COMMAND_BYTES - 1);

  cmd_mem_t   mem;
  cmd_index_t wr_idx;
  logic       wr_full;
  cmd_index_t rd_idx;
  logic       rd_done;
  cmd_index_t rd_sel;
  logic       rd_end;
  logic       rd_valid;

  // A rewind in the same cycle as a read serves byte 0 straight away
  assign rd_sel   = read_rewind ? '0 : rd_idx;
  assign rd_end   = read_rewind ? 1'b0 : rd_done;
  assign rd_valid = !rd_end && (wr_full || rd_sel < wr_idx);
  assign tx_byte  = rd_valid ? mem[rd_sel] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem     <= '0;
      wr_idx  <= '0;
      wr_full <= 1'b0;
      rd_idx  <= '0;
      rd_done <= 1'b0;
    end else begin
      if (cmd_rewind) begin
        wr_idx  <= '0;
        wr_full <= 1'b0;
      end else if (cmd_write && !wr_full) begin
        mem[wr_idx] <= cmd_data;
        // Once full, further bytes of the session are dropped
        if (wr_idx == LAST_INDEX) begin
          wr_full <= 1'b1;
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
      if (tx_next) begin
        if (rd_end || rd_sel == LAST_INDEX) begin
          rd_idx  <= rd_sel;
          rd_done <= 1'b1;
        end else begin
          rd_idx  <= rd_sel + 1'b1;
          rd_done <= 1'b0;
        end
      end else if (read_rewind) begin
        rd_idx  <= '0;
        rd_done <= 1'b0;
      end
    end
  end

endmodule

// File: hw/spi_router.sv
/*
  Arbiter and pin mux for the serial RAM.
  The MCU wins while in ACCESS_RAM; the coprocessor gets the RAM otherwise.
  Grants are registered, the pin paths themselves are combinational.
*/
`timescale 1ns/1ps

module spi_router (
  input  logic                       clk,
  input  logic                       reset,
  input  core_logic_pkg::mcu_state_t mcu_state,
  input  spi_pkg::spi_pins_t         mcu_pins,
  input  spi_pkg::spi_pins_t         cop_pins,
  input  logic                       cop_ram_sel,
  output logic                       ram_nss,
  output logic                       ram_sck,
  output logic                       ram_mosi,
  input  logic                       ram_miso,
  output logic                       mcu_miso,
  output logic                       cop_ram_miso
);
  import core_logic_pkg::*;

  logic cop_sel_meta;
  logic cop_sel_sync;
  logic mcu_wants;
  logic mcu_grant;
  logic cop_grant;

  assign mcu_wants = (mcu_state == ACCESS_RAM);

  always_ff @(posedge clk) begin
    if (reset) begin
      cop_sel_meta <= 1'b0;
      cop_sel_sync <= 1'b0;
      mcu_grant    <= 1'b0;
      cop_grant    <= 1'b0;
    end else begin
      // The coprocessor select comes straight from its pins
      cop_sel_meta <= cop_ram_sel;
      cop_sel_sync <= cop_sel_meta;
      // A grant is only taken while the other side is free, and kept until released
      mcu_grant <= mcu_wants && (mcu_grant || !cop_grant);
      cop_grant <= cop_sel_sync && (cop_grant || (!mcu_grant && !mcu_wants));
    end
  end

  always_comb begin
    // Idle bus with the RAM deselected
    ram_nss  = 1'b1;
    ram_sck  = 1'b0;
    ram_mosi = 1'b0;
    if (mcu_grant) begin
      ram_nss  = mcu_pins.nss;
      ram_sck  = mcu_pins.sck;
      ram_mosi = mcu_pins.mosi;
    end else if (cop_grant) begin
      ram_nss  = cop_pins.nss;
      ram_sck  = cop_pins.sck;
      ram_mosi = cop_pins.mosi;
    end
  end

  // The side without the grant reads zeros
  assign mcu_miso     = mcu_grant & ram_miso;
  assign cop_ram_miso = cop_grant & ram_miso;

endmodule

// File: hw/core_logic.sv
/*
  Top level of the board controller core logic.
  Connects the MCU and coprocessor SPI links, the MCU session decoder,
  the command buffer and the serial RAM router.
*/
`timescale 1ns/1ps
`include "core_logic_defines.svh"

module core_logic (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        mcu_nss,
  input  logic                        mcu_sck,
  input  logic                        mcu_mosi,
  output logic                        mcu_miso,
  input  logic [`DEV_SELECT_WIDTH-1:0] cop_nss,
  input  logic                        cop_sck,
  input  logic                        cop_mosi,
  output logic                        cop_miso,
  output logic                        ram_nss,
  output logic                        ram_sck,
  output logic                        ram_mosi,
  input  logic                        ram_miso
);
  import spi_pkg::*;
  import core_logic_pkg::*;

  spi_pins_t              mcu_pins;
  spi_pins_t              cop_cmd_pins;
  spi_pins_t              cop_ram_pins;
  spi_byte_t              mcu_rx;
  logic                   mcu_start;
  logic                   cop_start;
  logic                   cop_tx_next;
  logic [`BYTE_WIDTH-1:0] cop_tx_byte;
  logic                   cop_link_miso;
  logic                   cop_ram_miso;
  logic                   cop_ram_sel;
  mcu_state_t             mcu_state;
  logic                   cmd_write;
  logic                   cmd_rewind;
  logic [`BYTE_WIDTH-1:0] cmd_data;

  assign mcu_pins = '{nss: mcu_nss, sck: mcu_sck, mosi: mcu_mosi};

  // The coprocessor select is decoded into one active-low select per target
  assign cop_ram_sel  = (cop_nss == `DEV_SELECT_WIDTH'(`DEV_SELECT_RAM));
  assign cop_cmd_pins = '{nss: (cop_nss != `DEV_SELECT_WIDTH'(`DEV_SELECT_COMMAND)),
                          sck: cop_sck, mosi: cop_mosi};
  assign cop_ram_pins = '{nss: !cop_ram_sel, sck: cop_sck, mosi: cop_mosi};

  // The MCU link only receives; its answers come from the RAM through the router
  spi_byte_slave mcu_link (
    .clk(clk), .reset(reset), .pins(mcu_pins), .tx_byte('0),
    .rx(mcu_rx), .start(mcu_start), .tx_next(), .miso()
  );

  // Coprocessor command readback; data it sends is not used
  spi_byte_slave cop_link (
    .clk(clk), .reset(reset), .pins(cop_cmd_pins), .tx_byte(cop_tx_byte),
    .rx(), .start(cop_start), .tx_next(cop_tx_next), .miso(cop_link_miso)
  );

  mcu_state_machine u_state (
    .clk(clk), .reset(reset), .rx(mcu_rx), .start(mcu_start), .nss_high(mcu_nss),
    .mcu_state(mcu_state), .cmd_write(cmd_write), .cmd_data(cmd_data),
    .cmd_rewind(cmd_rewind)
  );

  command_buffer u_cmd (
    .clk(clk), .reset(reset), .cmd_write(cmd_write), .cmd_rewind(cmd_rewind),
    .cmd_data(cmd_data), .read_rewind(cop_start), .tx_next(cop_tx_next),
    .tx_byte(cop_tx_byte)
  );

  spi_router u_router (
    .clk(clk), .reset(reset), .mcu_state(mcu_state), .mcu_pins(mcu_pins),
    .cop_pins(cop_ram_pins), .cop_ram_sel(cop_ram_sel), .ram_nss(ram_nss),
    .ram_sck(ram_sck), .ram_mosi(ram_mosi), .ram_miso(ram_miso),
    .mcu_miso(mcu_miso), .cop_ram_miso(cop_ram_miso)
  );

  // The two coprocessor targets have exclusive selects, so at most one drives
  assign cop_miso = cop_link_miso | cop_ram_miso;

endmodule

// File: sim/tb_clock_gen.sv
/*
  Clock and reset source for the core logic testbench.
  Gives a 10 ns clock and holds reset high over the first 4 rising edges.
*/
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset drops 1 ns after the 4th rising edge, in step with the other inputs
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

// File: sim/core_logic_chk.sv
/*
  Concurrent assertions on the core logic, attached to core_logic by bind.
  They watch the reset state of the outputs and the RAM routing.
*/
`timescale 1ns/1ps

module core_logic_chk (
  input logic                       clk,
  input logic                       reset,
  input core_logic_pkg::mcu_state_t mcu_state,
  input logic                       mcu_nss,
  input logic                       cop_ram_sel,
  input logic                       ram_nss,
  input logic                       ram_sck,
  input logic                       mcu_miso,
  input logic                       cop_miso,
  input logic                       cop_ram_miso
);
  import core_logic_pkg::*;

  // A reset cycle leaves the RAM deselected, the miso lines low and the MCU idle
  reset_state_a: assert property (@(posedge clk)
    reset |=> ram_nss && !ram_sck && !mcu_miso && !cop_miso && mcu_state == IDLE)
    else $error("Outputs are not in their reset state after a reset cycle");

  // The RAM is only selected when one of the two sides selects it
  ram_select_a: assert property (@(posedge clk) disable iff (reset)
    !ram_nss |-> (!mcu_nss || cop_ram_sel))
    else $error("RAM selected while neither the MCU nor the coprocessor asks for it");

  // The MCU grant follows ACCESS_RAM by one cycle, so miso needs the state one cycle back
  mcu_miso_gate_a: assert property (@(posedge clk) disable iff (reset)
    mcu_miso |-> $past(mcu_state) == ACCESS_RAM)
    else $error("MCU receives RAM data outside an access-RAM session");

  // Grants are exclusive, so RAM data never reaches both sides
  miso_exclusive_a: assert property (@(posedge clk) disable iff (reset)
    !(mcu_miso && cop_ram_miso))
    else $error("RAM data routed to the MCU and the coprocessor at once");

endmodule

// File: sim/core_logic_tb.sv
/*
  Testbench for the board controller core logic.
  Runs MCU and coprocessor SPI sessions against an inverting RAM model and
  compares every returned byte with a reference function.
*/
`timescale 1ns/1ps
`include "core_logic_defines.svh"

module core_logic_tb;
  import core_logic_pkg::*;

  // SPI timing in clk cycles, one SCK period is two half periods
  localparam int HALF_SCK     = 4;
  localparam int BYTE_GAP     = 8;
  localparam int SELECT_SETUP = 8;
  localparam int SESSION_GAP  = 8;
  // All tests move about 30 bytes in 9 sessions
  localparam int BYTE_CYCLES    = 2 * `BYTE_WIDTH * HALF_SCK + BYTE_GAP;
  localparam int TRAFFIC_CYCLES = 30 * BYTE_CYCLES + 9 * (SELECT_SETUP + SESSION_GAP);
  localparam int TIMEOUT_CYCLES = 8 * (TRAFFIC_CYCLES + 200);

  // One returned byte waiting for the compare process
  typedef struct packed {
    logic                         from_cop;
    logic [`DEV_SELECT_WIDTH-1:0] target;
    logic [2:0]                   index;
    logic [`BYTE_WIDTH-1:0]       sent;
    logic [`BYTE_WIDTH-1:0]       got;
  } xfer_t;

  logic                         clk;
  logic                         reset;
  logic                         mcu_nss;
  logic                         mcu_sck;
  logic                         mcu_mosi;
  logic                         mcu_miso;
  logic [`DEV_SELECT_WIDTH-1:0] cop_nss;
  logic                         cop_sck;
  logic                         cop_mosi;
  logic                         cop_miso;
  logic                         ram_nss;
  logic                         ram_sck;
  logic                         ram_mosi;
  logic                         ram_miso;

  int          cycle_count   = 0;
  int          checks_done   = 0;
  int          errors_seen   = 0;
  int          test_errors   = 0;
  int          test_num      = 0;
  int          ram_nss_falls = 0;
  int          ram_sck_rises = 0;
  int          cmd_count     = 0;
  logic [31:0] rand_state    = 32'h5978;
  logic [`BYTE_WIDTH-1:0] cmd_model [`COMMAND_BYTES];
  xfer_t       xfer_q [$];

  tb_clock_gen clock_gen (.clk(clk), .reset(reset));

  core_logic uut (
    .clk(clk), .reset(reset),
    .mcu_nss(mcu_nss), .mcu_sck(mcu_sck), .mcu_mosi(mcu_mosi), .mcu_miso(mcu_miso),
    .cop_nss(cop_nss), .cop_sck(cop_sck), .cop_mosi(cop_mosi), .cop_miso(cop_miso),
    .ram_nss(ram_nss), .ram_sck(ram_sck), .ram_mosi(ram_mosi), .ram_miso(ram_miso)
  );

  // RAM model answers each bit with its inverse
  assign ram_miso = ~ram_mosi;

  bind core_logic core_logic_chk chk (
    .clk(clk), .reset(reset), .mcu_state(mcu_state), .mcu_nss(mcu_nss),
    .cop_ram_sel(cop_ram_sel), .ram_nss(ram_nss), .ram_sck(ram_sck),
    .mcu_miso(mcu_miso), .cop_miso(cop_miso), .cop_ram_miso(cop_ram_miso)
  );

  // Each RAM session shows up as one falling edge of ram_nss
  always @(negedge ram_nss) begin
    if (!reset) begin
      ram_nss_falls++;
    end
  end

  // Every data bit that reaches the RAM comes with one rising ram_sck
  always @(posedge ram_sck) begin
    if (!reset) begin
      ram_sck_rises++;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_random(output logic [`BYTE_WIDTH-1:0] value);
    rand_state = xorshift(rand_state);
    value = rand_state[`BYTE_WIDTH-1:0];
  endtask

  // Expected byte on miso for a given target
  // The RAM inverts, the command buffer replays the last command and pads with 0
  function automatic logic [`BYTE_WIDTH-1:0] expect_byte(
    input logic [`DEV_SELECT_WIDTH-1:0] target,
    input logic [`BYTE_WIDTH-1:0] sent,
    input int index
  );
    logic [`BYTE_WIDTH-1:0] result;
    result = '0;
    if (target == `DEV_SELECT_RAM) begin
      result = ~sent;
    end else if (target == `DEV_SELECT_COMMAND && index < cmd_count) begin
      result = cmd_model[index];
    end
    return result;
  endfunction

  task automatic check_byte(input string name, input logic [`BYTE_WIDTH-1:0] got,
                            input logic [`BYTE_WIDTH-1:0] exp);
    checks_done++;
    if (got !== exp) begin
      errors_seen++;
      test_errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_state(input mcu_state_t got, input mcu_state_t exp);
    checks_done++;
    if (got !== exp) begin
      errors_seen++;
      test_errors++;
      $display("FAILED at %0t: mcu_state got %s expected %s", $time, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks_done++;
    if (got !== exp) begin
      errors_seen++;
      test_errors++;
      $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks_done++;
    if (got != exp) begin
      errors_seen++;
      test_errors++;
      $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // Compare process, one posedge behind the transfers that queue the results
  initial begin : compare_results
    xfer_t item;
    forever begin
      @(posedge clk);
      while (xfer_q.size() > 0) begin
        item = xfer_q.pop_front();
        check_byte(item.from_cop ? "cop_miso" : "mcu_miso", item.got,
                   expect_byte(item.target, item.sent, item.index));
      end
    end
  end

  // Returns 1 ns after the n-th rising edge, where all inputs change
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Mode 0, LSB first; miso is read just before each rising SCK
  task automatic mcu_transfer(input logic [`BYTE_WIDTH-1:0] sent,
                              input logic [`DEV_SELECT_WIDTH-1:0] target);
    logic [`BYTE_WIDTH-1:0] got;
    int i;
    got = '0;
    for (i = 0; i < `BYTE_WIDTH; i++) begin
      mcu_mosi = sent[i];
      wait_cycles(HALF_SCK);
      got[i] = mcu_miso;
      mcu_sck = 1'b1;
      wait_cycles(HALF_SCK);
      mcu_sck = 1'b0;
    end
    wait_cycles(BYTE_GAP);
    xfer_q.push_back('{from_cop: 1'b0, target: target, index: 3'd0, sent: sent, got: got});
  endtask

  task automatic cop_transfer(input logic [`BYTE_WIDTH-1:0] sent,
                              input logic [`DEV_SELECT_WIDTH-1:0] target,
                              input logic [2:0] index);
    logic [`BYTE_WIDTH-1:0] got;
    int i;
    got = '0;
    for (i = 0; i < `BYTE_WIDTH; i++) begin
      cop_mosi = sent[i];
      wait_cycles(HALF_SCK);
      got[i] = cop_miso;
      cop_sck = 1'b1;
      wait_cycles(HALF_SCK);
      cop_sck = 1'b0;
    end
    wait_cycles(BYTE_GAP);
    xfer_q.push_back('{from_cop: 1'b1, target: target, index: index, sent: sent, got: got});
  endtask

  task automatic mcu_begin();
    mcu_nss = 1'b0;
    wait_cycles(SELECT_SETUP);
  endtask

  task automatic mcu_end();
    mcu_nss = 1'b1;
    wait_cycles(SESSION_GAP);
  endtask

  task automatic cop_begin(input logic [`DEV_SELECT_WIDTH-1:0] code);
    cop_nss = code;
    wait_cycles(SELECT_SETUP);
  endtask

  task automatic cop_end();
    cop_nss = `DEV_SELECT_NONE;
    wait_cycles(SESSION_GAP);
  endtask

  // One coprocessor session that reads the command buffer from its start
  task automatic read_commands(input int count);
    logic [`BYTE_WIDTH-1:0] sent;
    int i;
    cop_begin(`DEV_SELECT_COMMAND);
    for (i = 0; i < count; i++) begin
      next_random(sent);
      cop_transfer(sent, `DEV_SELECT_COMMAND, 3'(i));
    end
    cop_end();
  endtask

  task automatic finish_test(input string name);
    while (xfer_q.size() > 0) begin
      wait_cycles(1);
    end
    test_num++;
    $display("Test %0d %s: %0d errors", test_num, name, test_errors);
    test_errors = 0;
  endtask

  initial begin : stimulus
    logic [`BYTE_WIDTH-1:0] sent;
    int i;
    int falls_before;
    int rises_before;
    mcu_nss  = 1'b1;
    mcu_sck  = 1'b0;
    mcu_mosi = 1'b0;
    cop_nss  = `DEV_SELECT_NONE;
    cop_sck  = 1'b0;
    cop_mosi = 1'b0;
    wait (reset === 1'b0);
    wait_cycles(2);

    check_bit("ram_nss", ram_nss, 1'b1);
    check_bit("mcu_miso", mcu_miso, 1'b0);
    check_bit("cop_miso", cop_miso, 1'b0);
    check_state(uut.mcu_state, IDLE);
    finish_test("reset state");

    // Three command bytes, then a readback that runs one byte past them
    mcu_begin();
    mcu_transfer(`MCU_STATE_WRITE_COMMAND, `DEV_SELECT_NONE);
    cmd_count = 0;
    for (i = 0; i < 3; i++) begin
      next_random(sent);
      mcu_transfer(sent, `DEV_SELECT_NONE);
      cmd_model[cmd_count] = sent;
      cmd_count++;
    end
    mcu_end();
    check_state(uut.mcu_state, IDLE);
    read_commands(4);
    finish_test("write command and readback");

    // Opcode 65 has a nonzero class nibble
    falls_before = ram_nss_falls;
    rises_before = ram_sck_rises;
    mcu_begin();
    mcu_transfer(8'd65, `DEV_SELECT_NONE);
    for (i = 0; i < 2; i++) begin
      next_random(sent);
      mcu_transfer(sent, `DEV_SELECT_NONE);
    end
    check_state(uut.mcu_state, IGNORE);
    check_bit("ram_nss", ram_nss, 1'b1);
    mcu_end();
    check_count("ram_nss falls", ram_nss_falls, falls_before);
    check_count("ram_sck rises", ram_sck_rises, rises_before);
    read_commands(4);
    finish_test("unknown opcode ignored");

    falls_before = ram_nss_falls;
    rises_before = ram_sck_rises;
    mcu_begin();
    mcu_transfer(`MCU_STATE_ACCESS_RAM, `DEV_SELECT_NONE);
    check_state(uut.mcu_state, ACCESS_RAM);
    for (i = 0; i < 5; i++) begin
      next_random(sent);
      mcu_transfer(sent, `DEV_SELECT_RAM);
    end
    mcu_end();
    check_count("ram_nss falls", ram_nss_falls, falls_before + 1);
    // Only the five data bytes are clocked into the RAM, the opcode byte is not
    check_count("ram_sck rises", ram_sck_rises, rises_before + 5 * `BYTE_WIDTH);
    finish_test("MCU access to RAM");

    // Coprocessor gets the RAM while the MCU is idle
    falls_before = ram_nss_falls;
    rises_before = ram_sck_rises;
    cop_begin(`DEV_SELECT_RAM);
    for (i = 0; i < 4; i++) begin
      next_random(sent);
      cop_transfer(sent, `DEV_SELECT_RAM, 3'd0);
    end
    cop_end();
    // Then it is locked out while the MCU holds the RAM
    mcu_begin();
    mcu_transfer(`MCU_STATE_ACCESS_RAM, `DEV_SELECT_NONE);
    cop_begin(`DEV_SELECT_RAM);
    for (i = 0; i < 2; i++) begin
      next_random(sent);
      cop_transfer(sent, `DEV_SELECT_NONE, 3'd0);
    end
    cop_end();
    next_random(sent);
    mcu_transfer(sent, `DEV_SELECT_RAM);
    mcu_end();
    check_count("ram_nss falls", ram_nss_falls, falls_before + 2);
    // Four coprocessor bytes and one MCU byte, none from the locked out transfers
    check_count("ram_sck rises", ram_sck_rises, rises_before + 5 * `BYTE_WIDTH);
    finish_test("coprocessor access to RAM");

    falls_before = ram_nss_falls;
    mcu_begin();
    mcu_transfer(`MCU_STATE_OPCODE, `DEV_SELECT_NONE);
    check_state(uut.mcu_state, IDLE);
    mcu_end();
    check_state(uut.mcu_state, IDLE);
    check_count("ram_nss falls", ram_nss_falls, falls_before);
    finish_test("opcode 0 stays idle");

    $display("Tests: %0d, checks: %0d, errors: %0d", test_num, checks_done, errors_seen);
    if (errors_seen == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
hw/spi_pkg.sv
hw/core_logic_pkg.sv
hw/spi_byte_slave.sv
hw/mcu_state_machine.sv
hw/command_buffer.sv
hw/spi_router.sv
hw/core_logic.sv
sim/tb_clock_gen.sv
sim/core_logic_chk.sv
sim/core_logic_tb.sv

// File: Bender.yml
package:
  name: core_logic

export_include_dirs:
  - include

sources:
  - hw/spi_pkg.sv
  - hw/core_logic_pkg.sv
  - hw/spi_byte_slave.sv
  - hw/mcu_state_machine.sv
  - hw/command_buffer.sv
  - hw/spi_router.sv
  - hw/core_logic.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/core_logic_chk.sv
      - sim/core_logic_tb.sv
